/* mips_soc_bus.f */
verilog/mips_bus_pkg.sv
verilog/mips_irq_pkg.sv
verilog/bus_arbiter.sv
verilog/unified_memory.sv
verilog/system_bridge.sv
verilog/interval_timer.sv
verilog/mips_soc_bus.sv
sim/mips_soc_bus_tb.sv

/* sim/mips_soc_bus_tb.sv */
module mips_soc_bus_tb
	import mips_bus_pkg::*;
	import mips_irq_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT_CYCLES = 200;
	localparam int BURST_LEN = 6;
	localparam int RANDOM_ROUNDS = 24;

	logic                  clk;
	logic                  reset;
	logic                  fetch_req_valid;
	logic [ADDR_W-1:0]     fetch_addr;
	logic                  fetch_credit;
	logic                  fetch_resp_valid;
	logic [DATA_W-1:0]     fetch_rdata;
	logic                  data_req_valid;
	logic [ADDR_W-1:0]     data_addr;
	logic [BYTE_LANES-1:0] data_byteen;
	logic [DATA_W-1:0]     data_wdata;
	logic                  data_credit;
	logic                  data_resp_valid;
	logic [DATA_W-1:0]     data_rdata;
	logic                  interrupt;
	logic [IRQ_W-1:0]      hw_int;

	int seed;
	int error_count;
	logic watch_tmr1;

	// Fetch master: pending commands, responses in arrival order
	logic [ADDR_W-1:0] fetch_cmd_q[$];
	logic [DATA_W-1:0] fetch_resp_q[$];
	int fetch_credits;
	int fetch_min_credits;
	int fetch_tags;

	logic [ADDR_W-1:0]     data_cmd_addr_q[$];
	logic [BYTE_LANES-1:0] data_cmd_byteen_q[$];
	logic [DATA_W-1:0]     data_cmd_wdata_q[$];
	logic [DATA_W-1:0]     data_resp_q[$];
	int data_credits;
	int data_min_credits;
	int data_tags;

	logic [DATA_W-1:0] model_mem [MEM_WORDS];

	mips_soc_bus i_dut (
		.clk(clk),
		.reset(reset),
		.fetch_req_valid(fetch_req_valid),
		.fetch_addr(fetch_addr),
		.fetch_credit(fetch_credit),
		.fetch_resp_valid(fetch_resp_valid),
		.fetch_rdata(fetch_rdata),
		.data_req_valid(data_req_valid),
		.data_addr(data_addr),
		.data_byteen(data_byteen),
		.data_wdata(data_wdata),
		.data_credit(data_credit),
		.data_resp_valid(data_resp_valid),
		.data_rdata(data_rdata),
		.interrupt(interrupt),
		.hw_int(hw_int)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic stop_run(input string reason);
		error_count++;
		$display("%s", reason);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_value(input string what, input logic [DATA_W-1:0] actual,
			input logic [DATA_W-1:0] expected);
		if (actual !== expected)
			stop_run($sformatf("Error: %0.1f ns: %s: got %h, expected %h",
				$realtime, what, actual, expected));
	endtask

	function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
			input logic [DATA_W-1:0] new_word, input logic [BYTE_LANES-1:0] lanes);
		logic [DATA_W-1:0] mask;
		for (int i = 0; i < BYTE_LANES; i++)
			mask[8*i +: 8] = {8{lanes[i]}};
		return (old_word & ~mask) | (new_word & mask);
	endfunction

	// Fetch master: take back credits, collect responses, then issue
	always @(negedge clk) begin
		if (reset) begin
			fetch_credits = PORT_CREDITS;
			fetch_min_credits = PORT_CREDITS;
			fetch_req_valid = 1'b0;
		end else begin
			if (fetch_credit) begin
				fetch_credits++;
				if (fetch_credits > PORT_CREDITS)
					stop_run("fetch port was handed more credits than it may hold");
			end
			if (fetch_resp_valid)
				fetch_resp_q.push_back(fetch_rdata);
			fetch_req_valid = 1'b0;
			if (fetch_cmd_q.size() != 0 && fetch_credits > 0) begin
				fetch_addr = fetch_cmd_q.pop_front();
				fetch_req_valid = 1'b1;
				fetch_credits--;
				if (fetch_credits < fetch_min_credits)
					fetch_min_credits = fetch_credits;
			end
		end
	end

	always @(negedge clk) begin
		if (reset) begin
			data_credits = PORT_CREDITS;
			data_min_credits = PORT_CREDITS;
			data_req_valid = 1'b0;
		end else begin
			if (data_credit) begin
				data_credits++;
				if (data_credits > PORT_CREDITS)
					stop_run("data port was handed more credits than it may hold");
			end
			if (data_resp_valid)
				data_resp_q.push_back(data_rdata);
			data_req_valid = 1'b0;
			if (data_cmd_addr_q.size() != 0 && data_credits > 0) begin
				data_addr = data_cmd_addr_q.pop_front();
				data_byteen = data_cmd_byteen_q.pop_front();
				data_wdata = data_cmd_wdata_q.pop_front();
				data_req_valid = 1'b1;
				data_credits--;
				if (data_credits < data_min_credits)
					data_min_credits = data_credits;
			end
		end
	end

	always @(negedge clk) begin
		if (watch_tmr1 && hw_int[IRQ_TIMER1])
			stop_run("masked timer1 raised its interrupt bit");
	end

	task automatic fetch_send(input logic [ADDR_W-1:0] addr, output int tag);
		tag = fetch_tags;
		fetch_tags++;
		fetch_cmd_q.push_back(addr);
	endtask

	task automatic data_send(input logic [ADDR_W-1:0] addr, input logic [BYTE_LANES-1:0] lanes,
			input logic [DATA_W-1:0] wdata, output int tag);
		tag = data_tags;
		data_tags++;
		data_cmd_addr_q.push_back(addr);
		data_cmd_byteen_q.push_back(lanes);
		data_cmd_wdata_q.push_back(wdata);
	endtask

	task automatic fetch_wait(input int tag, output logic [DATA_W-1:0] rdata);
		int waited;
		waited = 0;
		while (fetch_resp_q.size() <= tag) begin
			@(posedge clk);
			waited++;
			if (waited > TIMEOUT_CYCLES)
				stop_run("timed out waiting for a fetch response");
		end
		rdata = fetch_resp_q[tag];
	endtask

	task automatic data_wait(input int tag, output logic [DATA_W-1:0] rdata);
		int waited;
		waited = 0;
		while (data_resp_q.size() <= tag) begin
			@(posedge clk);
			waited++;
			if (waited > TIMEOUT_CYCLES)
				stop_run("timed out waiting for a data response");
		end
		rdata = data_resp_q[tag];
	endtask

	task automatic fetch_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] rdata);
		int tag;
		fetch_send(addr, tag);
		fetch_wait(tag, rdata);
	endtask

	task automatic data_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] rdata);
		int tag;
		data_send(addr, '0, '0, tag);
		data_wait(tag, rdata);
	endtask

	// Memory writes also land in the model
	task automatic data_write(input logic [ADDR_W-1:0] addr, input logic [BYTE_LANES-1:0] lanes,
			input logic [DATA_W-1:0] wdata);
		int tag;
		logic [DATA_W-1:0] ignored;
		data_send(addr, lanes, wdata, tag);
		data_wait(tag, ignored);
		if (addr < DEV_BASE)
			model_mem[addr[MEM_AW+1:2]] = merge_bytes(model_mem[addr[MEM_AW+1:2]], wdata, lanes);
	endtask

	task automatic test_reset_state();
		int ftag[PORT_CREDITS];
		int dtag[PORT_CREDITS];
		logic [DATA_W-1:0] rdata;
		@(negedge clk);
		check_value("hw_int after reset", DATA_W'(hw_int), '0);
		check_value("fetch credit after reset", DATA_W'(fetch_credit), '0);
		check_value("data credit after reset", DATA_W'(data_credit), '0);
		check_value("fetch resp_valid after reset", DATA_W'(fetch_resp_valid), '0);
		check_value("data resp_valid after reset", DATA_W'(data_resp_valid), '0);
		@(posedge clk);
		for (int i = 0; i < PORT_CREDITS; i++) begin
			fetch_send(TIMER0_BASE + TIMER_PRESET, ftag[i]);
			data_send(TIMER1_BASE + TIMER_PRESET, '0, '0, dtag[i]);
		end
		for (int i = 0; i < PORT_CREDITS; i++) begin
			fetch_wait(ftag[i], rdata);
			check_value("timer0 preset via fetch", rdata, '0);
			data_wait(dtag[i], rdata);
			check_value("timer1 preset via data", rdata, '0);
		end
		// Every slot's credit has come back
		check_value("fetch credits returned", fetch_credits, PORT_CREDITS);
		check_value("data credits returned", data_credits, PORT_CREDITS);
	endtask

	task automatic test_random_rw();
		logic [ADDR_W-1:0]     addr;
		logic [BYTE_LANES-1:0] lanes;
		logic [DATA_W-1:0]     wdata;
		logic [DATA_W-1:0]     rdata;
		int widx;
		for (int n = 0; n < RANDOM_ROUNDS; n++) begin
			widx = ($random(seed) & 32'h7fff_ffff) % (DEV_BASE >> 2);
			addr = ADDR_W'(widx) << 2;
			wdata = $random(seed);
			data_write(addr, '1, wdata);
			lanes = $random(seed);
			if (lanes == '0)
				lanes = BYTE_LANES'(1);
			wdata = $random(seed);
			data_write(addr, lanes, wdata);
			data_read(addr, rdata);
			check_value($sformatf("data read at %h", addr), rdata, model_mem[widx]);
			fetch_read(addr, rdata);
			check_value($sformatf("fetch read at %h", addr), rdata, model_mem[widx]);
		end
	endtask

	task automatic test_concurrent();
		int ftag[BURST_LEN];
		int dtag[BURST_LEN];
		logic [ADDR_W-1:0] base;
		logic [DATA_W-1:0] rdata;
		base = 32'h0000_0400;
		for (int i = 0; i < BURST_LEN; i++)
			data_write(base + 4*i, '1, {16'hbeef, 16'(i)} ^ 32'h0051_0000);
		fetch_min_credits = PORT_CREDITS;
		data_min_credits = PORT_CREDITS;
		// Data walks the same words backwards so a swapped response shows up
		for (int i = 0; i < BURST_LEN; i++) begin
			fetch_send(base + 4*i, ftag[i]);
			data_send(base + 4*(BURST_LEN-1-i), '0, '0, dtag[i]);
		end
		for (int i = 0; i < BURST_LEN; i++) begin
			fetch_wait(ftag[i], rdata);
			check_value("fetch burst order", rdata, model_mem[(base >> 2) + i]);
		end
		for (int i = 0; i < BURST_LEN; i++) begin
			data_wait(dtag[i], rdata);
			check_value("data burst order", rdata, model_mem[(base >> 2) + BURST_LEN-1-i]);
		end
		check_value("fetch credits ran out under contention", fetch_min_credits, 0);
		check_value("data credits ran out under contention", data_min_credits, 0);
		check_value("fetch credits after burst", fetch_credits, PORT_CREDITS);
		check_value("data credits after burst", data_credits, PORT_CREDITS);
	endtask

	task automatic test_timers();
		logic [DATA_W-1:0] rdata;
		int waited;
		watch_tmr1 = 1'b1;
		data_write(TIMER1_BASE + TIMER_PRESET, '1, 32'd8);
		data_write(TIMER1_BASE + TIMER_CTRL, '1, DATA_W'(1 << CTRL_ENABLE));
		data_write(TIMER0_BASE + TIMER_PRESET, '1, 32'd12);
		data_write(TIMER0_BASE + TIMER_CTRL, '1, DATA_W'((1 << CTRL_ENABLE) |
			(int'(MODE_ONESHOT) << CTRL_MODE) | (1 << CTRL_IRQ_MASK)));
		waited = 0;
		@(negedge clk);
		while (!hw_int[IRQ_TIMER0]) begin
			@(negedge clk);
			waited++;
			if (waited > TIMEOUT_CYCLES)
				stop_run("timed out waiting for the timer0 interrupt");
		end
		check_value("hw_int with timer0 expired", DATA_W'(hw_int), DATA_W'(1 << IRQ_TIMER0));
		@(posedge clk);
		data_read(TIMER0_BASE + TIMER_COUNT, rdata);
		check_value("timer0 count after expiry", rdata, '0);
		data_read(TIMER0_BASE + TIMER_CTRL, rdata);
		check_value("timer0 enable after expiry", DATA_W'(rdata[CTRL_ENABLE]), '0);
		// Timer1 must run out too while its bit stays low
		waited = 0;
		data_read(TIMER1_BASE + TIMER_COUNT, rdata);
		while (rdata != '0) begin
			data_read(TIMER1_BASE + TIMER_COUNT, rdata);
			waited++;
			if (waited > TIMEOUT_CYCLES)
				stop_run("timer1 never counted down to zero");
		end
		data_read(TIMER1_BASE + TIMER_CTRL, rdata);
		check_value("timer1 enable after expiry", DATA_W'(rdata[CTRL_ENABLE]), '0);
		watch_tmr1 = 1'b0;
		data_write(TIMER0_BASE + TIMER_CTRL, '1, '0);
		@(negedge clk);
		check_value("hw_int after timer0 ctrl write", DATA_W'(hw_int), '0);
	endtask

	task automatic test_ext_interrupt();
		logic [DATA_W-1:0] rdata;
		@(negedge clk);
		interrupt = 1'b1;
		@(negedge clk);
		interrupt = 1'b0;
		check_value("ext bit after pin rise", DATA_W'(hw_int[IRQ_EXT]), 1);
		repeat (4) @(negedge clk);
		check_value("ext bit after pin drop", DATA_W'(hw_int[IRQ_EXT]), 1);
		@(posedge clk);
		data_read(INT_ACK_ADDR, rdata);
		@(negedge clk);
		check_value("ext bit after ack read", DATA_W'(hw_int[IRQ_EXT]), 1);
		@(posedge clk);
		data_write(INT_ACK_ADDR, BYTE_LANES'(1), '0);
		@(negedge clk);
		check_value("ext bit after ack write", DATA_W'(hw_int[IRQ_EXT]), 0);
	endtask

	initial begin
		seed = 32'h518c3499;
		error_count = 0;
		watch_tmr1 = 1'b0;
		fetch_tags = 0;
		data_tags = 0;
		fetch_credits = PORT_CREDITS;
		data_credits = PORT_CREDITS;
		fetch_min_credits = PORT_CREDITS;
		data_min_credits = PORT_CREDITS;
		reset = 1'b1;
		fetch_req_valid = 1'b0;
		fetch_addr = '0;
		data_req_valid = 1'b0;
		data_addr = '0;
		data_byteen = '0;
		data_wdata = '0;
		interrupt = 1'b0;
		repeat (8) @(negedge clk);
		reset = 1'b0;
		@(posedge clk);
		test_reset_state();
		test_random_rw();
		test_concurrent();
		test_timers();
		test_ext_interrupt();
		if (error_count == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* verilog/bus_arbiter.sv */
module bus_arbiter
	import mips_bus_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  fetch_req_valid,
	input  logic [ADDR_W-1:0]     fetch_addr,
	output logic                  fetch_credit,
	output logic                  fetch_resp_valid,
	output logic [DATA_W-1:0]     fetch_rdata,
	input  logic                  data_req_valid,
	input  logic [ADDR_W-1:0]     data_addr,
	input  logic [BYTE_LANES-1:0] data_byteen,
	input  logic [DATA_W-1:0]     data_wdata,
	output logic                  data_credit,
	output logic                  data_resp_valid,
	output logic [DATA_W-1:0]     data_rdata,
	output logic                  bus_valid,
	output logic [ADDR_W-1:0]     bus_addr,
	output logic [BYTE_LANES-1:0] bus_byteen,
	output logic [DATA_W-1:0]     bus_wdata,
	input  logic [DATA_W-1:0]     bus_rdata
);
	logic [ADDR_W-1:0]     fq_addr [PORT_CREDITS];
	logic [QUEUE_PTR_W-1:0] fq_wr_ptr;
	logic [QUEUE_PTR_W-1:0] fq_rd_ptr;
	logic [QUEUE_CNT_W-1:0] fq_count;
	logic [ADDR_W-1:0]     dq_addr [PORT_CREDITS];
	logic [BYTE_LANES-1:0] dq_byteen [PORT_CREDITS];
	logic [DATA_W-1:0]     dq_wdata [PORT_CREDITS];
	bus_op_t               dq_op [PORT_CREDITS];
	logic [QUEUE_PTR_W-1:0] dq_wr_ptr;
	logic [QUEUE_PTR_W-1:0] dq_rd_ptr;
	logic [QUEUE_CNT_W-1:0] dq_count;
	logic                  grant_fetch;
	logic                  grant_data;
	logic                  last_data;
	logic                  bus_port;
	logic                  inflight;
	bus_op_t               head_op;

	// Round robin, the port not served last wins a tie
	assign grant_fetch = (fq_count != '0) && ((dq_count == '0) || last_data);
	assign grant_data = (dq_count != '0) && !grant_fetch;
	assign bus_valid = grant_fetch || grant_data;

	// Fetch cycles are always reads
	assign head_op = grant_data ? dq_op[dq_rd_ptr] : OP_READ;
	assign bus_addr = grant_data ? dq_addr[dq_rd_ptr] : fq_addr[fq_rd_ptr];
	assign bus_byteen = (head_op == OP_WRITE) ? dq_byteen[dq_rd_ptr] : '0;
	assign bus_wdata = grant_data ? dq_wdata[dq_rd_ptr] : '0;

	// A slot frees as soon as its request goes out
	assign fetch_credit = grant_fetch;
	assign data_credit = grant_data;

	always_ff @(posedge clk) begin
		if (fetch_req_valid)
			fq_addr[fq_wr_ptr] <= fetch_addr;
		if (data_req_valid) begin
			dq_addr[dq_wr_ptr] <= data_addr;
			dq_byteen[dq_wr_ptr] <= data_byteen;
			dq_wdata[dq_wr_ptr] <= data_wdata;
			dq_op[dq_wr_ptr] <= (|data_byteen) ? OP_WRITE : OP_READ;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			fq_wr_ptr <= '0;
			fq_rd_ptr <= '0;
			fq_count <= '0;
			dq_wr_ptr <= '0;
			dq_rd_ptr <= '0;
			dq_count <= '0;
			last_data <= 1'b1;
			inflight <= 1'b0;
			bus_port <= PORT_FETCH;
		end else begin
			if (fetch_req_valid)
				fq_wr_ptr <= fq_wr_ptr + 1'b1;
			if (grant_fetch)
				fq_rd_ptr <= fq_rd_ptr + 1'b1;
			fq_count <= fq_count + QUEUE_CNT_W'(fetch_req_valid) - QUEUE_CNT_W'(grant_fetch);
			if (data_req_valid)
				dq_wr_ptr <= dq_wr_ptr + 1'b1;
			if (grant_data)
				dq_rd_ptr <= dq_rd_ptr + 1'b1;
			dq_count <= dq_count + QUEUE_CNT_W'(data_req_valid) - QUEUE_CNT_W'(grant_data);
			if (bus_valid)
				last_data <= grant_data;
			inflight <= bus_valid;
			bus_port <= grant_data ? PORT_DATA : PORT_FETCH;
		end
	end

	// Bridge answers one cycle after issue
	assign fetch_resp_valid = inflight && (bus_port == PORT_FETCH);
	assign data_resp_valid = inflight && (bus_port == PORT_DATA);
	assign fetch_rdata = bus_rdata;
	assign data_rdata = bus_rdata;

	// Master sent a request without holding a credit
	// A full queue still takes a request when its head issues in the same cycle
	assert property (@(posedge clk) disable iff (reset)
		fetch_req_valid |-> (fq_count != QUEUE_CNT_W'(PORT_CREDITS)) || grant_fetch)
		else $error("fetch request on a full queue");
	assert property (@(posedge clk) disable iff (reset)
		data_req_valid |-> (dq_count != QUEUE_CNT_W'(PORT_CREDITS)) || grant_data)
		else $error("data request on a full queue");

	// Each issued cycle comes back to exactly one port
	assert property (@(posedge clk) disable iff (reset)
		bus_valid |=> $onehot({fetch_resp_valid, data_resp_valid}))
		else $error("response routed to more than one port");

endmodule

/* verilog/interval_timer.sv */
module interval_timer
	import mips_bus_pkg::*;
	import mips_irq_pkg::*;
(
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      sel,
	input  logic [TIMER_OFFSET_W-1:0] offset,
	input  logic [BYTE_LANES-1:0]     byteen,
	input  logic [DATA_W-1:0]         wdata,
	output logic [DATA_W-1:0]         rdata,
	output logic                      irq
);
	logic [CTRL_W-1:0] ctrl;
	logic [DATA_W-1:0] preset;
	logic [DATA_W-1:0] count;
	logic              oneshot_hold;
	logic              reload_pulse;
	logic              wr_en;
	logic [DATA_W-1:0] cur_word;
	logic [DATA_W-1:0] merged;
	timer_mode_t       mode;

	function automatic logic [DATA_W-1:0] byte_merge(
		input logic [DATA_W-1:0]     old_word,
		input logic [DATA_W-1:0]     new_word,
		input logic [BYTE_LANES-1:0] lanes
	);
		logic [DATA_W-1:0] result;
		result = old_word;
		for (int i = 0; i < BYTE_LANES; i++) begin
			if (lanes[i])
				result[8*i +: 8] = new_word[8*i +: 8];
		end
		return result;
	endfunction

	always_comb begin
		case (offset)
			TIMER_CTRL:   cur_word = DATA_W'(ctrl);
			TIMER_PRESET: cur_word = preset;
			TIMER_COUNT:  cur_word = count;
			default:      cur_word = '0;
		endcase
	end

	assign merged = byte_merge(cur_word, wdata, byteen);
	assign wr_en = sel && (|byteen);
	assign mode = timer_mode_t'(ctrl[CTRL_MODE]);

	// Mask bit set lets the interrupt out
	assign irq = ctrl[CTRL_IRQ_MASK] && (oneshot_hold || reload_pulse);

	// Register writes take priority over counting; count is read only
	always_ff @(posedge clk) begin
		if (reset) begin
			ctrl <= '0;
			preset <= '0;
			count <= '0;
			oneshot_hold <= 1'b0;
			reload_pulse <= 1'b0;
		end else begin
			reload_pulse <= 1'b0;
			if (wr_en && offset == TIMER_CTRL) begin
				ctrl <= merged[CTRL_W-1:0];
				oneshot_hold <= 1'b0;
			end else if (wr_en && offset == TIMER_PRESET) begin
				preset <= merged;
				count <= merged;
			end else if (ctrl[CTRL_ENABLE] && count != '0) begin
				if (count == DATA_W'(1)) begin
					if (mode == MODE_RELOAD) begin
						count <= preset;
						reload_pulse <= 1'b1;
					end else begin
						count <= '0;
						ctrl[CTRL_ENABLE] <= 1'b0;
						oneshot_hold <= 1'b1;
					end
				end else begin
					count <= count - 1'b1;
				end
			end
		end
	end

	// Read data lines up with memory latency
	always_ff @(posedge clk) begin
		if (sel)
			rdata <= cur_word;
	end

endmodule

/* verilog/mips_bus_pkg.sv */
package mips_bus_pkg;

	// Bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int BYTE_LANES = DATA_W / 8;

	// Unified memory, word addressed
	localparam int MEM_WORDS = 8192;
	localparam int MEM_AW = $clog2(MEM_WORDS);

	// Address map
	// Memory sits below DEV_BASE, devices from DEV_BASE up
	localparam logic [ADDR_W-1:0] DEV_BASE = 32'h0000_7f00;
	localparam logic [ADDR_W-1:0] TIMER0_BASE = 32'h0000_7f00;
	localparam logic [ADDR_W-1:0] TIMER1_BASE = 32'h0000_7f10;
	localparam logic [ADDR_W-1:0] INT_ACK_ADDR = 32'h0000_7f20;

	// Credit flow control, one queue slot per credit
	localparam int PORT_CREDITS = 2;
	localparam int QUEUE_PTR_W = $clog2(PORT_CREDITS);
	localparam int QUEUE_CNT_W = $clog2(PORT_CREDITS + 1);

	// Owner of a bus cycle
	localparam logic PORT_FETCH = 1'b0;
	localparam logic PORT_DATA = 1'b1;

	// Write when any byte enable is set
	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} bus_op_t;

endpackage

/* verilog/mips_irq_pkg.sv */
package mips_irq_pkg;

	// Timer register window is 16 bytes
	localparam int TIMER_OFFSET_W = 4;

	localparam logic [TIMER_OFFSET_W-1:0] TIMER_CTRL = 4'h0;
	localparam logic [TIMER_OFFSET_W-1:0] TIMER_PRESET = 4'h4;
	localparam logic [TIMER_OFFSET_W-1:0] TIMER_COUNT = 4'h8;

	// Control register bits
	localparam int CTRL_W = 4;
	localparam int CTRL_ENABLE = 0;
	localparam int CTRL_MODE = 1;
	localparam int CTRL_IRQ_MASK = 3;

	typedef enum logic {
		MODE_ONESHOT = 1'b0,
		MODE_RELOAD  = 1'b1
	} timer_mode_t;

	// Hardware interrupt vector
	localparam int IRQ_W = 3;
	localparam int IRQ_TIMER0 = 0;
	localparam int IRQ_TIMER1 = 1;
	localparam int IRQ_EXT = 2;

endpackage

/* verilog/mips_soc_bus.sv */
module mips_soc_bus
	import mips_bus_pkg::*;
	import mips_irq_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  fetch_req_valid,
	input  logic [ADDR_W-1:0]     fetch_addr,
	output logic                  fetch_credit,
	output logic                  fetch_resp_valid,
	output logic [DATA_W-1:0]     fetch_rdata,
	input  logic                  data_req_valid,
	input  logic [ADDR_W-1:0]     data_addr,
	input  logic [BYTE_LANES-1:0] data_byteen,
	input  logic [DATA_W-1:0]     data_wdata,
	output logic                  data_credit,
	output logic                  data_resp_valid,
	output logic [DATA_W-1:0]     data_rdata,
	input  logic                  interrupt,
	output logic [IRQ_W-1:0]      hw_int
);
	logic                      bus_valid;
	logic [ADDR_W-1:0]         bus_addr;
	logic [BYTE_LANES-1:0]     bus_byteen;
	logic [DATA_W-1:0]         bus_wdata;
	logic [DATA_W-1:0]         bus_rdata;
	logic                      mem_sel;
	logic [ADDR_W-1:0]         mem_addr;
	logic [BYTE_LANES-1:0]     mem_byteen;
	logic [DATA_W-1:0]         mem_wdata;
	logic [DATA_W-1:0]         mem_rdata;
	logic                      tmr0_sel;
	logic                      tmr1_sel;
	logic [TIMER_OFFSET_W-1:0] dev_offset;
	logic [BYTE_LANES-1:0]     dev_byteen;
	logic [DATA_W-1:0]         dev_wdata;
	logic [DATA_W-1:0]         tmr0_rdata;
	logic [DATA_W-1:0]         tmr1_rdata;
	logic                      tmr0_irq;
	logic                      tmr1_irq;

	bus_arbiter i_arbiter (
		.clk(clk),
		.reset(reset),
		.fetch_req_valid(fetch_req_valid),
		.fetch_addr(fetch_addr),
		.fetch_credit(fetch_credit),
		.fetch_resp_valid(fetch_resp_valid),
		.fetch_rdata(fetch_rdata),
		.data_req_valid(data_req_valid),
		.data_addr(data_addr),
		.data_byteen(data_byteen),
		.data_wdata(data_wdata),
		.data_credit(data_credit),
		.data_resp_valid(data_resp_valid),
		.data_rdata(data_rdata),
		.bus_valid(bus_valid),
		.bus_addr(bus_addr),
		.bus_byteen(bus_byteen),
		.bus_wdata(bus_wdata),
		.bus_rdata(bus_rdata)
	);

	system_bridge i_bridge (
		.clk(clk),
		.reset(reset),
		.bus_valid(bus_valid),
		.bus_addr(bus_addr),
		.bus_byteen(bus_byteen),
		.bus_wdata(bus_wdata),
		.bus_rdata(bus_rdata),
		.mem_sel(mem_sel),
		.mem_addr(mem_addr),
		.mem_byteen(mem_byteen),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata),
		.tmr0_sel(tmr0_sel),
		.tmr1_sel(tmr1_sel),
		.dev_offset(dev_offset),
		.dev_byteen(dev_byteen),
		.dev_wdata(dev_wdata),
		.tmr0_rdata(tmr0_rdata),
		.tmr1_rdata(tmr1_rdata),
		.tmr0_irq(tmr0_irq),
		.tmr1_irq(tmr1_irq),
		.interrupt(interrupt),
		.hw_int(hw_int)
	);

	unified_memory i_memory (
		.clk(clk),
		.mem_sel(mem_sel),
		.mem_addr(mem_addr),
		.mem_byteen(mem_byteen),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata)
	);

	interval_timer i_timer0 (
		.clk(clk),
		.reset(reset),
		.sel(tmr0_sel),
		.offset(dev_offset),
		.byteen(dev_byteen),
		.wdata(dev_wdata),
		.rdata(tmr0_rdata),
		.irq(tmr0_irq)
	);

	interval_timer i_timer1 (
		.clk(clk),
		.reset(reset),
		.sel(tmr1_sel),
		.offset(dev_offset),
		.byteen(dev_byteen),
		.wdata(dev_wdata),
		.rdata(tmr1_rdata),
		.irq(tmr1_irq)
	);

endmodule

/* verilog/system_bridge.sv */
module system_bridge
	import mips_bus_pkg::*;
	import mips_irq_pkg::*;
(
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      bus_valid,
	input  logic [ADDR_W-1:0]         bus_addr,
	input  logic [BYTE_LANES-1:0]     bus_byteen,
	input  logic [DATA_W-1:0]         bus_wdata,
	output logic [DATA_W-1:0]         bus_rdata,
	output logic                      mem_sel,
	output logic [ADDR_W-1:0]         mem_addr,
	output logic [BYTE_LANES-1:0]     mem_byteen,
	output logic [DATA_W-1:0]         mem_wdata,
	input  logic [DATA_W-1:0]         mem_rdata,
	output logic                      tmr0_sel,
	output logic                      tmr1_sel,
	output logic [TIMER_OFFSET_W-1:0] dev_offset,
	output logic [BYTE_LANES-1:0]     dev_byteen,
	output logic [DATA_W-1:0]         dev_wdata,
	input  logic [DATA_W-1:0]         tmr0_rdata,
	input  logic [DATA_W-1:0]         tmr1_rdata,
	input  logic                      tmr0_irq,
	input  logic                      tmr1_irq,
	input  logic                      interrupt,
	output logic [IRQ_W-1:0]          hw_int
);
	bus_op_t bus_op;
	logic    hit_mem;
	logic    hit_tmr0;
	logic    hit_tmr1;
	logic    hit_ack;
	logic    ack_write;
	logic    rd_mem_q;
	logic    rd_tmr0_q;
	logic    rd_tmr1_q;
	logic    ext_pending;

	assign bus_op = (|bus_byteen) ? OP_WRITE : OP_READ;

	// Address decode
	assign hit_mem = bus_addr < DEV_BASE;
	assign hit_tmr0 = bus_addr[ADDR_W-1:TIMER_OFFSET_W] == TIMER0_BASE[ADDR_W-1:TIMER_OFFSET_W];
	assign hit_tmr1 = bus_addr[ADDR_W-1:TIMER_OFFSET_W] == TIMER1_BASE[ADDR_W-1:TIMER_OFFSET_W];
	assign hit_ack = bus_addr[ADDR_W-1:2] == INT_ACK_ADDR[ADDR_W-1:2];

	assign mem_sel = bus_valid && hit_mem;
	assign mem_addr = bus_addr;
	assign mem_byteen = bus_byteen;
	assign mem_wdata = bus_wdata;

	assign tmr0_sel = bus_valid && hit_tmr0;
	assign tmr1_sel = bus_valid && hit_tmr1;
	assign dev_offset = bus_addr[TIMER_OFFSET_W-1:0];
	assign dev_byteen = bus_byteen;
	assign dev_wdata = bus_wdata;

	// Remember who answers next cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			rd_mem_q <= 1'b0;
			rd_tmr0_q <= 1'b0;
			rd_tmr1_q <= 1'b0;
		end else begin
			rd_mem_q <= mem_sel;
			rd_tmr0_q <= tmr0_sel;
			rd_tmr1_q <= tmr1_sel;
		end
	end

	// Ack register and unmapped space read as zero
	always_comb begin
		if (rd_mem_q)
			bus_rdata = mem_rdata;
		else if (rd_tmr0_q)
			bus_rdata = tmr0_rdata;
		else if (rd_tmr1_q)
			bus_rdata = tmr1_rdata;
		else
			bus_rdata = '0;
	end

	// External interrupt latch, any write to the ack word clears it
	assign ack_write = bus_valid && hit_ack && (bus_op == OP_WRITE);

	always_ff @(posedge clk) begin
		if (reset)
			ext_pending <= 1'b0;
		else if (ack_write)
			ext_pending <= 1'b0;
		else if (interrupt)
			ext_pending <= 1'b1;
	end

	always_comb begin
		hw_int = '0;
		hw_int[IRQ_TIMER0] = tmr0_irq;
		hw_int[IRQ_TIMER1] = tmr1_irq;
		hw_int[IRQ_EXT] = ext_pending;
	end

endmodule

/* verilog/unified_memory.sv */
module unified_memory
	import mips_bus_pkg::*;
(
	input  logic                  clk,
	input  logic                  mem_sel,
	input  logic [ADDR_W-1:0]     mem_addr,
	input  logic [BYTE_LANES-1:0] mem_byteen,
	input  logic [DATA_W-1:0]     mem_wdata,
	output logic [DATA_W-1:0]     mem_rdata
);
	logic [DATA_W-1:0] mem [MEM_WORDS];
	logic [MEM_AW-1:0] word_idx;

	// Byte address in, low two bits pick a lane only
	assign word_idx = mem_addr[MEM_AW+1:2];

	// Per-lane write, read returns the word before this edge's write
	always_ff @(posedge clk) begin
		if (mem_sel) begin
			for (int lane = 0; lane < BYTE_LANES; lane++) begin
				if (mem_byteen[lane])
					mem[word_idx][8*lane +: 8] <= mem_wdata[8*lane +: 8];
			end
			mem_rdata <= mem[word_idx];
		end
	end

	// Bridge must never route device space here
	assert property (@(posedge clk)
		mem_sel |-> mem_addr < DEV_BASE)
		else $error("memory selected above device base: %h", mem_addr);

endmodule
